// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_uart_master
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
verilog/uart_frame_pkg.sv
verilog/reg_cmd_pkg.sv
verilog/cmd_dispatch.sv
verilog/uart_link.sv
verilog/read_collect.sv
verilog/uart_master_top.sv
test/uart_checker.sv
test/tb_uart_master.sv

// ==== test/tb_uart_master.sv ====
`timescale 1ns/1ps

module tb_uart_master;

  import reg_cmd_pkg::*;
  import uart_frame_pkg::*;

  localparam int num_ch      = 4;
  localparam int baud_div    = 8;
  localparam int gap_bits    = 2;
  localparam int chan_w      = $clog2(num_ch);
  localparam int num_cmds    = 60;
  localparam int watchdog_ns = num_cmds * 40 * baud_div * 20; // 40 bit-times per command

  logic                   clk;
  logic                   rst_n;
  cmd_word_u              cmd_in;
  logic [chan_w-1:0]      cmd_chan;
  logic                   cmd_vld;
  logic                   cmd_rdy;
  logic [num_ch-1:0]      tx;
  logic [num_ch-1:0]      rx;
  logic                   read_vld;
  logic [data_w-1:0]      read_data;
  logic [chan_w-1:0]      read_chan;
  logic                   read_err;
  logic [num_ch-1:0]      frm_vld;
  logic [num_ch-1:0][7:0] frm_byte;
  logic [num_ch-1:0]      frm_bad;
  logic [num_ch-1:0]      frm_gap_short;
  int                     mismatches;
  int                     failures;
  int                     outstanding;

  uart_master_top #(
    .NUM_CH   (num_ch),
    .BAUD_DIV (baud_div),
    .GAP_BITS (gap_bits)
  ) u_uart_master_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_chan  (cmd_chan),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .rx        (rx),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_chan (read_chan),
    .read_err  (read_err)
  );

  uart_checker #(
    .NUM_CH (num_ch)
  ) u_uart_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_chan      (cmd_chan),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx            (tx),
    .read_vld      (read_vld),
    .read_data     (read_data),
    .read_chan     (read_chan),
    .read_err      (read_err),
    .frm_vld       (frm_vld),
    .frm_byte      (frm_byte),
    .frm_bad       (frm_bad),
    .frm_gap_short (frm_gap_short),
    .mismatches    (mismatches),
    .failures      (failures),
    .outstanding   (outstanding)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // returns at 2 ns past the edge that took the command
  task automatic send_cmd(input logic [chan_w-1:0] chan, input cmd_word_u word);
    cmd_chan = chan;
    cmd_in   = word;
    cmd_vld  = 1'b1;
    @(negedge clk);
    while (!cmd_rdy)
      @(negedge clk);
    @(posedge clk);
    #2;
    cmd_vld = 1'b0;
  endtask

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  for (genvar g = 0; g < num_ch; g++)
  begin : g_dev
    logic       rx_line;
    logic       f_vld;
    logic [7:0] f_byte;
    logic       f_bad;
    logic       f_gap;
    bit   [7:0] mem [128];

    assign rx[g]            = rx_line;
    assign frm_vld[g]       = f_vld;
    assign frm_byte[g]      = f_byte;
    assign frm_bad[g]       = f_bad;
    assign frm_gap_short[g] = f_gap;

    // entered on the first falling clock edge that sees the start bit
    task automatic get_frame(output logic [7:0] b, output logic bad);
      logic [frame_bits-1:0] bits;
      repeat (baud_div / 2) @(negedge clk);
      bits[0] = tx[g];
      for (int k = 1; k < frame_bits; k++)
      begin
        repeat (baud_div) @(negedge clk);
        bits[k] = tx[g];
      end
      b   = bits[8:1];
      bad = bits[0] | (^bits[9:1]) | ~bits[10]; // even parity over data and parity bit
    endtask

    task automatic post_frame(input logic [7:0] b, input logic bad, input logic gap);
      f_byte = b;
      f_bad  = bad;
      f_gap  = gap;
      f_vld  = 1'b1;
      @(negedge clk);
      f_vld  = 1'b0;
    endtask

    task automatic send_reply(input logic [7:0] b, input logic flip);
      logic [frame_bits-1:0] bits;
      bits = {1'b1, (^b) ^ flip, b, 1'b0};
      repeat (3 * baud_div) @(posedge clk);
      for (int k = 0; k < frame_bits; k++)
      begin
        @(posedge clk);
        #2;
        rx_line = bits[k];
        repeat (baud_div - 1) @(posedge clk);
      end
    endtask

    initial
    begin
      logic [7:0] b;
      logic [7:0] d;
      logic       bad;
      logic       bad_d;
      int         gap_cnt;
      rx_line = 1'b1;
      f_vld   = 1'b0;
      f_byte  = 8'h00;
      f_bad   = 1'b0;
      f_gap   = 1'b0;
      forever
      begin
        @(negedge clk);
        if (rst_n && tx[g] === 1'b0)
        begin
          get_frame(b, bad);
          post_frame(b, bad, 1'b0);
          if (b[7]) // rw rides in the top bit of the address byte
          begin
            gap_cnt = 1;
            while (tx[g] !== 1'b0)
            begin
              @(negedge clk);
              gap_cnt++;
            end
            // the count also holds the rest of the stop bit after its mid-bit sample
            get_frame(d, bad_d);
            post_frame(d, bad_d, gap_cnt < gap_bits * baud_div + baud_div / 2);
            mem[b[6:0]] = d;
          end
          else
          begin
            send_reply(mem[b[6:0]], b[6:0] == 7'h7f);
          end
        end
      end
    end
  end

  initial
  begin
    logic [31:0]       seed;
    cmd_word_u         word;
    logic [chan_w-1:0] chan;
    rst_n    = 1'b0;
    cmd_vld  = 1'b0;
    cmd_in   = '0;
    cmd_chan = '0;
    seed     = 32'h7a77;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    for (int n = 0; n < num_cmds; n++)
    begin
      seed = lcg_next(seed);
      // one read per channel first so that all links run at once
      chan          = (n < num_ch) ? chan_w'(n) : seed[31 -: chan_w];
      word.wr.rw    = (n < num_ch) ? op_read : seed[27];
      word.wr.addr  = (seed[26:24] == 3'd7) ? 7'h7f : {4'd0, seed[22:20]};
      word.wr.wdata = seed[15:8];
      send_cmd(chan, word);
    end
    wait (outstanding == 0);
    repeat (20 * baud_div) @(posedge clk); // room for a stray frame or strobe
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== test/uart_checker.sv ====
`timescale 1ns/1ps

module uart_checker #(
  parameter int NUM_CH = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  reg_cmd_pkg::cmd_word_u        cmd_in,
  input  logic [$clog2(NUM_CH)-1:0]     cmd_chan,
  input  logic                          cmd_vld,
  input  logic                          cmd_rdy,
  input  logic [NUM_CH-1:0]             tx,
  input  logic                          read_vld,
  input  logic [reg_cmd_pkg::data_w-1:0] read_data,
  input  logic [$clog2(NUM_CH)-1:0]     read_chan,
  input  logic                          read_err,
  input  logic [NUM_CH-1:0]             frm_vld,
  input  logic [NUM_CH-1:0][7:0]        frm_byte,
  input  logic [NUM_CH-1:0]             frm_bad,
  input  logic [NUM_CH-1:0]             frm_gap_short,
  output int                            mismatches,
  output int                            failures,
  output int                            outstanding
);

  import reg_cmd_pkg::*;

  logic [8:0] exp_frame [NUM_CH][$]; // top bit marks the address frame of a read
  logic [8:0] exp_read  [NUM_CH][$]; // {err, data} in command order
  bit   [7:0] regs      [NUM_CH][128];
  bit         idle_checked;

  task automatic note_mismatch(input string test, input int ch, input logic [8:0] exp,
                               input logic [8:0] act);
    $display("MISMATCH %s ch%0d: expected %h, actual %h", test, ch, exp, act);
    mismatches++;
  endtask

  task automatic flag_failure(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    failures++;
  endtask

  always @(posedge clk)
  begin
    logic [8:0] e;
    int         total;
    string      test;
    if (rst_n)
    begin
      if (!idle_checked)
      begin
        idle_checked = 1'b1;
        if (tx !== '1 || cmd_rdy !== 1'b1 || read_vld !== 1'b0)
          flag_failure("reset_idle: tx, cmd_rdy or read_vld is not idle after reset");
      end
      if (cmd_vld && cmd_rdy)
      begin
        if (exp_frame[cmd_chan].size() != 0)
          flag_failure($sformatf("channel_concurrency: command taken on busy channel %0d",
                                 cmd_chan));
        exp_frame[cmd_chan].push_back({cmd_in.wr.rw == op_read, cmd_in.wr.rw, cmd_in.wr.addr});
        if (cmd_in.wr.rw == op_write)
        begin
          exp_frame[cmd_chan].push_back({1'b0, cmd_in.wr.wdata});
          regs[cmd_chan][cmd_in.wr.addr] = cmd_in.wr.wdata;
        end
        else
        begin
          // the device answers address 7f with the stored byte but broken parity
          exp_read[cmd_chan].push_back({cmd_in.rd.addr == 7'h7f, regs[cmd_chan][cmd_in.rd.addr]});
        end
      end
      for (int i = 0; i < NUM_CH; i++)
      begin
        if (frm_vld[i] && exp_frame[i].size() == 0)
        begin
          flag_failure($sformatf("channel_concurrency: unexpected frame on tx[%0d]", i));
        end
        else if (frm_vld[i])
        begin
          e = exp_frame[i].pop_front();
          if (e[8])
            test = "read_back";
          else
            test = "write_frames";
          if (frm_byte[i] !== e[7:0])
            note_mismatch(test, i, {1'b0, e[7:0]}, {1'b0, frm_byte[i]});
          if (frm_bad[i])
            flag_failure($sformatf("%s: bad start, parity or stop bit on tx[%0d]", test, i));
          if (frm_gap_short[i])
            flag_failure($sformatf("write_frames: gap before data frame too short on tx[%0d]", i));
        end
      end
      if (read_vld && exp_read[read_chan].size() == 0)
      begin
        flag_failure($sformatf("read_back: read strobe on channel %0d with no read pending",
                               read_chan));
      end
      else if (read_vld)
      begin
        e = exp_read[read_chan].pop_front();
        if (e[8])
          test = "parity_error";
        else
          test = "read_back";
        if ({read_err, read_data} !== e)
          note_mismatch(test, int'(read_chan), e, {read_err, read_data});
      end
    end
    total = 0;
    for (int i = 0; i < NUM_CH; i++)
      total += exp_frame[i].size() + exp_read[i].size();
    outstanding = total;
  end

endmodule

// ==== verilog/cmd_dispatch.sv ====
`timescale 1ns/1ps

module cmd_dispatch #(
  parameter int NUM_CH = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  reg_cmd_pkg::cmd_word_u    cmd_in,
  input  logic [$clog2(NUM_CH)-1:0] cmd_chan,
  input  logic                      cmd_vld,
  output logic                      cmd_rdy,
  input  logic [NUM_CH-1:0]         busy,
  output logic [NUM_CH-1:0]         start,
  output reg_cmd_pkg::cmd_word_u    link_cmd
);

  logic chan_ok;
  logic accept;

  assign chan_ok = int'(cmd_chan) < NUM_CH; // channel numbers past NUM_CH-1 never get ready

  // start covers the one cycle before the link raises busy
  assign cmd_rdy = chan_ok && !busy[cmd_chan] && !start[cmd_chan];
  assign accept  = cmd_vld && cmd_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      start <= '0;
    end
    else if (accept)
    begin
      start <= NUM_CH'(1) << cmd_chan; // one-cycle pulse to the chosen link
    end
    else
    begin
      start <= '0;
    end
  end

  // shared by all links, each one copies it on its own start
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      link_cmd <= cmd_in;
    end
  end

endmodule

// ==== verilog/read_collect.sv ====
`timescale 1ns/1ps

module read_collect #(
  parameter int NUM_CH = 4
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic [NUM_CH-1:0]                          done,
  input  logic [NUM_CH-1:0][reg_cmd_pkg::data_w-1:0] rd_data,
  input  logic [NUM_CH-1:0]                          rd_err,
  output logic                                       read_vld,
  output logic [reg_cmd_pkg::data_w-1:0]             read_data,
  output logic [$clog2(NUM_CH)-1:0]                  read_chan,
  output logic                                       read_err
);

  import reg_cmd_pkg::*;

  localparam int chan_w = $clog2(NUM_CH);

  logic [NUM_CH-1:0]              pending;
  logic [NUM_CH-1:0][data_w-1:0]  slot_data;
  logic [NUM_CH-1:0]              slot_err;
  logic [chan_w-1:0]              ptr;
  logic                           take;

  assign take = pending[ptr]; // pointer steps every cycle, so a slot waits at most NUM_CH cycles

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pending  <= '0;
      ptr      <= '0;
      read_vld <= 1'b0;
    end
    else
    begin
      read_vld <= take;
      pending <= (take ? pending & ~(NUM_CH'(1) << ptr) : pending) | done; // new result wins
      ptr     <= (ptr == chan_w'(NUM_CH - 1)) ? '0 : ptr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < NUM_CH; i++)
    begin
      if (done[i])
      begin
        slot_data[i] <= rd_data[i];
        slot_err[i]  <= rd_err[i];
      end
    end
    if (take)
    begin
      read_data <= slot_data[ptr];
      read_chan <= ptr;
      read_err  <= slot_err[ptr];
    end
  end

endmodule

// ==== verilog/reg_cmd_pkg.sv ====
package reg_cmd_pkg;

  localparam int addr_w = 7;
  localparam int data_w = 8;
  localparam int cmd_w  = 1 + addr_w + data_w; // rw bit on top

  localparam logic op_write = 1'b1;
  localparam logic op_read  = 1'b0;

  // one host command word, seen as a write or as a read
  typedef union packed {
    struct packed {
      logic              rw;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wdata;
    } wr;
    struct packed {
      logic              rw;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] unused; // ignored by the link on reads
    } rd;
  } cmd_word_u;

endpackage

// ==== verilog/uart_frame_pkg.sv ====
package uart_frame_pkg;

  localparam int frame_bits = 11; // start, eight data bits, parity, stop

  // bit positions inside one frame, counted from the start bit
  localparam int start_pos  = 0;
  localparam int data_lsb   = 1;
  localparam int parity_pos = frame_bits - 2;
  localparam int stop_pos   = frame_bits - 1;

  localparam logic start_lvl = 1'b0;
  localparam logic stop_lvl  = 1'b1; // also the idle level of the line

  // parity bit = parity_even ^ (^data) gives an even count of ones
  localparam logic parity_even = 1'b0;

  typedef enum logic [3:0] {
    st_idle,
    st_addr_start, st_addr_data, st_addr_par, st_addr_stop,
    st_gap,
    st_wd_start, st_wd_data, st_wd_par, st_wd_stop,
    st_reply_wait,
    st_reply_data, st_reply_par, st_reply_stop
  } link_state_t;

endpackage

// ==== verilog/uart_link.sv ====
`timescale 1ns/1ps

module uart_link #(
  parameter int BAUD_DIV = 434,
  parameter int GAP_BITS = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  reg_cmd_pkg::cmd_word_u        cmd,
  output logic                          busy,
  output logic                          tx,
  input  logic                          rx,
  output logic                          done,
  output logic [reg_cmd_pkg::data_w-1:0] rd_data,
  output logic                          rd_err
);

  import uart_frame_pkg::*;
  import reg_cmd_pkg::*;

  localparam int bw    = $clog2(BAUD_DIV + BAUD_DIV / 2);
  localparam int cnt_w = $clog2((GAP_BITS > 8 ? GAP_BITS : 8) + 1);

  localparam logic [bw-1:0]    baud_last = bw'(BAUD_DIV - 1);
  localparam logic [bw-1:0]    half_last = bw'(BAUD_DIV + BAUD_DIV / 2 - 1); // start edge to mid of bit 0
  localparam logic [cnt_w-1:0] last_bit  = cnt_w'(parity_pos - data_lsb - 1);
  localparam logic [cnt_w-1:0] gap_last  = cnt_w'(GAP_BITS - 1);

  link_state_t       state;
  logic [bw-1:0]     baud_cnt;
  logic [cnt_w-1:0]  bit_cnt;
  logic              tick;
  logic              rx_meta;
  logic              rx_s;
  cmd_word_u         cmd_q;
  logic [data_w-1:0] tx_byte;
  logic              tx_par;
  logic [data_w-1:0] rx_shreg;
  logic              rx_par;

  assign tick   = baud_cnt == '0;
  assign busy   = state != st_idle;
  assign tx_par = parity_even ^ (^tx_byte);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= stop_lvl;
      done     <= 1'b0;
      rx_meta  <= 1'b1;
      rx_s     <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
      done    <= 1'b0;
      if (tick)
        baud_cnt <= baud_last;
      else
        baud_cnt <= baud_cnt - 1'b1;
      case (state)
        st_idle:
        begin
          if (start)
          begin
            state    <= st_addr_start;
            tx       <= start_lvl;
            baud_cnt <= baud_last;
          end
        end
        st_addr_start, st_wd_start:
        begin
          if (tick)
          begin
            state   <= (state == st_addr_start) ? st_addr_data : st_wd_data;
            tx      <= tx_byte[0]; // LSB goes first
            bit_cnt <= '0;
          end
        end
        st_addr_data, st_wd_data:
        begin
          if (tick && bit_cnt == last_bit)
          begin
            state <= (state == st_addr_data) ? st_addr_par : st_wd_par;
            tx    <= tx_par;
          end
          else if (tick)
          begin
            tx      <= tx_byte[bit_cnt[2:0] + 3'd1];
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        st_addr_par, st_wd_par:
        begin
          if (tick)
          begin
            state <= (state == st_addr_par) ? st_addr_stop : st_wd_stop;
            tx    <= stop_lvl;
          end
        end
        st_addr_stop:
        begin
          if (tick)
          begin
            state   <= (cmd_q.wr.rw == op_write) ? st_gap : st_reply_wait;
            bit_cnt <= '0;
          end
        end
        st_gap:
        begin
          if (tick && bit_cnt == gap_last)
          begin
            state <= st_wd_start;
            tx    <= start_lvl;
          end
          else if (tick)
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        st_wd_stop:
        begin
          if (tick)
            state <= st_idle;
        end
        st_reply_wait:
        begin
          if (rx_s == start_lvl) // no timeout, a silent device holds the link here
          begin
            state    <= st_reply_data;
            baud_cnt <= half_last;
            bit_cnt  <= '0;
          end
        end
        st_reply_data:
        begin
          if (tick && bit_cnt == last_bit)
            state <= st_reply_par;
          else if (tick)
            bit_cnt <= bit_cnt + 1'b1;
        end
        st_reply_par:
        begin
          if (tick)
            state <= st_reply_stop;
        end
        st_reply_stop:
        begin
          if (tick)
          begin
            state <= st_idle;
            done  <= 1'b1;
          end
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == st_idle && start)
    begin
      cmd_q   <= cmd;
      tx_byte <= {cmd.rd.rw, cmd.rd.addr}; // address byte, rw rides in the top bit
    end
    if (state == st_gap && tick && bit_cnt == gap_last)
      tx_byte <= cmd_q.wr.wdata;
    if (state == st_reply_data && tick)
      rx_shreg <= {rx_s, rx_shreg[data_w-1:1]};
    if (state == st_reply_par && tick)
      rx_par <= rx_s;
    if (state == st_reply_stop && tick)
    begin
      rd_data <= rx_shreg;
      rd_err  <= (rx_par ^ parity_even ^ (^rx_shreg)) | (rx_s != stop_lvl);
    end
  end

endmodule

// ==== verilog/uart_master_top.sv ====
`timescale 1ns/1ps

module uart_master_top #(
  parameter int NUM_CH   = 4,
  parameter int BAUD_DIV = 434,
  parameter int GAP_BITS = 2
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  reg_cmd_pkg::cmd_word_u         cmd_in,
  input  logic [$clog2(NUM_CH)-1:0]      cmd_chan,
  input  logic                           cmd_vld,
  output logic                           cmd_rdy,
  output logic [NUM_CH-1:0]              tx,
  input  logic [NUM_CH-1:0]              rx,
  output logic                           read_vld,
  output logic [reg_cmd_pkg::data_w-1:0] read_data,
  output logic [$clog2(NUM_CH)-1:0]      read_chan,
  output logic                           read_err
);

  import reg_cmd_pkg::*;

  cmd_word_u                     link_cmd;
  logic [NUM_CH-1:0]             start;
  logic [NUM_CH-1:0]             busy;
  logic [NUM_CH-1:0]             done;
  logic [NUM_CH-1:0][data_w-1:0] rd_data;
  logic [NUM_CH-1:0]             rd_err;

  cmd_dispatch #(
    .NUM_CH (NUM_CH)
  ) u_cmd_dispatch (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_chan (cmd_chan),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .busy     (busy),
    .start    (start),
    .link_cmd (link_cmd)
  );

  for (genvar i = 0; i < NUM_CH; i++)
  begin : g_link
    uart_link #(
      .BAUD_DIV (BAUD_DIV),
      .GAP_BITS (GAP_BITS)
    ) u_uart_link (
      .clk     (clk),
      .rst_n   (rst_n),
      .start   (start[i]),
      .cmd     (link_cmd),
      .busy    (busy[i]),
      .tx      (tx[i]),
      .rx      (rx[i]),
      .done    (done[i]),
      .rd_data (rd_data[i]),
      .rd_err  (rd_err[i])
    );
  end

  read_collect #(
    .NUM_CH (NUM_CH)
  ) u_read_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .done      (done),
    .rd_data   (rd_data),
    .rd_err    (rd_err),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_chan (read_chan),
    .read_err  (read_err)
  );

endmodule
